// ==== bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    // datapath and predictor geometry
    localparam int XLEN          = 32;
    localparam int HIST_WIDTH    = 16;  // global history length
    localparam int TAG_WIDTH     = 10;  // tagged table tag
    localparam int BTB_TAG_WIDTH = 22;  // target buffer tag

    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [XLEN-1:0]       inst_t;
    typedef logic [HIST_WIDTH-1:0] hist_t;

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;
    localparam ctr_t CTR_WEAK_T    = 2'b10;
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    // tagged table entry, 13 bits
    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
        ctr_t                 ctr;
    } tag_entry_t;

    // target buffer entry, 55 bits
    typedef struct packed {
        logic                     valid;
        logic [BTB_TAG_WIDTH-1:0] tag;
        addr_t                    target;
    } btb_entry_t;

    // rv32i control transfer opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire

// ==== bpu_table.sv ====
`timescale 1ns/1ps
`default_nettype none

// direct-mapped storage shared by the counter, tagged and target tables
module bpu_table #(
    parameter type      payload_t   = logic [1:0],
    parameter int       DEPTH       = 256,
    parameter payload_t RESET_VALUE = '0
) (
    input  wire                       clk,
    input  wire                       rst,
    // prediction read
    input  wire  [$clog2(DEPTH)-1:0]  pred_index_i,
    output payload_t                  pred_data_o,
    // update read
    input  wire  [$clog2(DEPTH)-1:0]  upd_index_i,
    output payload_t                  upd_data_o,
    // write port
    input  wire                       wr_en_i,
    input  wire  [$clog2(DEPTH)-1:0]  wr_index_i,
    input  payload_t                  wr_data_i
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VALUE;
            end
        end else if (wr_en_i) begin
            mem[wr_index_i] <= wr_data_i;
        end
    end

    // both reads see the array after the last edge
    assign pred_data_o = mem[pred_index_i];
    assign upd_data_o  = mem[upd_index_i];

endmodule

`default_nettype wire

// ==== bpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_decode import bpu_pkg::*; (
    input  inst_t inst_i,
    output logic  is_branch_o,
    output logic  is_jal_o,
    output logic  is_jalr_o,
    output addr_t b_imm_o,
    output addr_t j_imm_o
);

    logic [6:0] opcode;

    assign opcode = inst_i[6:0];

    // only the three control transfer classes matter here
    assign is_branch_o = (opcode == OPC_BRANCH);
    assign is_jal_o    = (opcode == OPC_JAL);
    assign is_jalr_o   = (opcode == OPC_JALR);

    // b-type offset, bit 0 always zero
    assign b_imm_o = {
        {20{inst_i[31]}},   // sign
        inst_i[7],          // imm[11]
        inst_i[30:25],      // imm[10:5]
        inst_i[11:8],       // imm[4:1]
        1'b0
    };

    // j-type offset, +/- 1 MiB range
    assign j_imm_o = {
        {12{inst_i[31]}},   // sign
        inst_i[19:12],      // imm[19:12]
        inst_i[20],         // imm[11]
        inst_i[30:21],      // imm[10:1]
        1'b0
    };

endmodule

`default_nettype wire

// ==== bpu_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_lookup import bpu_pkg::*; #(
    parameter int BIM_ENTRIES = 512,
    parameter int TAG_ENTRIES = 256,
    parameter int BTB_ENTRIES = 256
) (
    input  addr_t                           pc_i,
    input  hist_t                           history_i,
    input  wire                             is_branch_i,
    input  wire                             is_jal_i,
    input  wire                             is_jalr_i,
    input  addr_t                           b_imm_i,
    input  addr_t                           j_imm_i,
    // table indices for this fetch
    output logic [$clog2(BIM_ENTRIES)-1:0]  bim_index_o,
    output logic [$clog2(TAG_ENTRIES)-1:0]  tag_index_o,
    output logic [$clog2(BTB_ENTRIES)-1:0]  btb_index_o,
    // entries read back from the tables
    input  ctr_t                            bim_data_i,
    input  tag_entry_t                      tag_data_i,
    input  btb_entry_t                      btb_data_i,
    // prediction
    output logic                            pred_branch_o,
    output logic                            pred_taken_o,
    output addr_t                           pred_target_o
);

    localparam int BIM_IW = $clog2(BIM_ENTRIES);
    localparam int TAG_IW = $clog2(TAG_ENTRIES);
    localparam int BTB_IW = $clog2(BTB_ENTRIES);

    logic [TAG_WIDTH-1:0]     tag_val;
    logic [BTB_TAG_WIDTH-1:0] btb_tag_val;
    logic                     tag_hit;
    logic                     btb_hit;
    logic                     dir_taken;
    addr_t                    pc_plus4;

    // index hashing
    assign bim_index_o = pc_i[2 +: BIM_IW];
    assign tag_index_o = pc_i[2 +: TAG_IW] ^ history_i[TAG_IW-1:0];
    assign btb_index_o = pc_i[2 +: BTB_IW];

    // tag folds the upper pc bits with the oldest history
    assign tag_val     = pc_i[2+TAG_IW +: TAG_WIDTH] ^ history_i[HIST_WIDTH-1 -: TAG_WIDTH];
    assign btb_tag_val = pc_i[XLEN-1 -: BTB_TAG_WIDTH];

    assign tag_hit = tag_data_i.valid && (tag_data_i.tag == tag_val);
    assign btb_hit = btb_data_i.valid && (btb_data_i.tag == btb_tag_val);

    // tagged table overrides bimodal when it matches
    assign dir_taken = tag_hit ? tag_data_i.ctr[1] : bim_data_i[1];

    assign pc_plus4 = pc_i + addr_t'(4);

    always_comb begin
        pred_branch_o = 1'b0;
        pred_taken_o  = 1'b0;
        pred_target_o = pc_plus4;
        if (is_jalr_i) begin
            pred_branch_o = 1'b1;
            if (btb_hit) begin     // register target, buffer is the only source
                pred_taken_o  = 1'b1;
                pred_target_o = btb_data_i.target;
            end
        end else if (is_jal_i) begin
            pred_branch_o = 1'b1;
            pred_taken_o  = 1'b1;
            pred_target_o = btb_hit ? btb_data_i.target : pc_i + j_imm_i;
        end else if (is_branch_i) begin
            pred_branch_o = 1'b1;
            pred_taken_o  = dir_taken;
            if (dir_taken) begin
                pred_target_o = btb_hit ? btb_data_i.target : pc_i + b_imm_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bpu_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_update import bpu_pkg::*; #(
    parameter int BIM_ENTRIES = 512,
    parameter int TAG_ENTRIES = 256,
    parameter int BTB_ENTRIES = 256
) (
    input  wire                             clk,
    input  wire                             rst,
    // execute stage feedback
    input  wire                             ex_valid_i,
    input  wire                             ex_taken_i,
    input  wire                             ex_correct_i,
    input  addr_t                           ex_pc_i,
    input  hist_t                           ex_history_i,
    input  addr_t                           ex_target_i,
    output hist_t                           history_o,
    // read back through the tables' update ports
    output logic [$clog2(BIM_ENTRIES)-1:0]  bim_index_o,
    output logic [$clog2(TAG_ENTRIES)-1:0]  tag_index_o,
    input  ctr_t                            bim_data_i,
    input  tag_entry_t                      tag_data_i,
    // table writes
    output logic                            bim_wr_en_o,
    output ctr_t                            bim_wr_data_o,
    output logic                            tag_wr_en_o,
    output tag_entry_t                      tag_wr_data_o,
    output logic                            btb_wr_en_o,
    output logic [$clog2(BTB_ENTRIES)-1:0]  btb_wr_index_o,
    output btb_entry_t                      btb_wr_data_o
);

    localparam int BIM_IW = $clog2(BIM_ENTRIES);
    localparam int TAG_IW = $clog2(TAG_ENTRIES);
    localparam int BTB_IW = $clog2(BTB_ENTRIES);

    hist_t                history_q;
    logic [TAG_WIDTH-1:0] tag_u;
    logic                 tag_hit_u;

    // one saturating step toward the resolved direction
    function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
        ctr_t res;
        res = ctr;
        if (taken && ctr != CTR_STRONG_T) begin
            res = ctr + ctr_t'(1);
        end else if (!taken && ctr != CTR_STRONG_NT) begin
            res = ctr - ctr_t'(1);
        end
        return res;
    endfunction

    // global history, newest outcome in bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history_q <= '0;
        end else if (ex_valid_i) begin
            history_q <= {history_q[HIST_WIDTH-2:0], ex_taken_i};
        end
    end

    assign history_o = history_q;

    // same hashing as the lookup, but with the history the prediction saw
    assign bim_index_o = ex_pc_i[2 +: BIM_IW];
    assign tag_index_o = ex_pc_i[2 +: TAG_IW] ^ ex_history_i[TAG_IW-1:0];
    assign tag_u       = ex_pc_i[2+TAG_IW +: TAG_WIDTH]
                       ^ ex_history_i[HIST_WIDTH-1 -: TAG_WIDTH];
    assign tag_hit_u   = tag_data_i.valid && (tag_data_i.tag == tag_u);

    // bimodal trains on every resolved branch
    assign bim_wr_en_o   = ex_valid_i;
    assign bim_wr_data_o = ctr_step(bim_data_i, ex_taken_i);

    // tagged entry trains on a hit, allocates on a mispredicted miss
    assign tag_wr_en_o = ex_valid_i && (tag_hit_u || !ex_correct_i);

    always_comb begin
        tag_wr_data_o.valid = 1'b1;
        tag_wr_data_o.tag   = tag_u;
        if (tag_hit_u && ex_correct_i) begin
            tag_wr_data_o.ctr = ctr_step(tag_data_i.ctr, ex_taken_i);
        end else if (tag_hit_u) begin
            tag_wr_data_o.ctr = ex_taken_i ? CTR_STRONG_T : CTR_STRONG_NT;  // wrong, jump to strong
        end else begin
            tag_wr_data_o.ctr = ex_taken_i ? CTR_WEAK_T : CTR_WEAK_NT;      // fresh entry
        end
    end

    // target buffer only learns taken transfers
    assign btb_wr_en_o          = ex_valid_i && ex_taken_i;
    assign btb_wr_index_o       = ex_pc_i[2 +: BTB_IW];
    assign btb_wr_data_o.valid  = 1'b1;
    assign btb_wr_data_o.tag    = ex_pc_i[XLEN-1 -: BTB_TAG_WIDTH];
    assign btb_wr_data_o.target = ex_target_i;

endmodule

`default_nettype wire

// ==== bpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_top import bpu_pkg::*; #(
    parameter int BIM_ENTRIES = 512,
    parameter int TAG_ENTRIES = 256,
    parameter int BTB_ENTRIES = 256
) (
    input  wire   clk,
    input  wire   rst,
    input  addr_t if_pc_i,
    input  inst_t if_inst_i,
    input  wire   ex_valid_i,
    input  wire   ex_taken_i,
    input  wire   ex_correct_i,
    input  addr_t ex_pc_i,
    input  hist_t ex_history_i,
    input  addr_t ex_target_i,
    output logic  pred_branch_o,
    output logic  pred_taken_o,
    output addr_t pred_target_o,
    output hist_t history_o
);

    localparam int BIM_IW = $clog2(BIM_ENTRIES);
    localparam int TAG_IW = $clog2(TAG_ENTRIES);
    localparam int BTB_IW = $clog2(BTB_ENTRIES);

    logic              is_branch, is_jal, is_jalr;
    addr_t             b_imm, j_imm;
    logic [BIM_IW-1:0] bim_pred_idx, bim_upd_idx;
    logic [TAG_IW-1:0] tag_pred_idx, tag_upd_idx;
    logic [BTB_IW-1:0] btb_pred_idx, btb_wr_idx;
    ctr_t              bim_pred_data, bim_upd_data, bim_wr_data;
    tag_entry_t        tag_pred_data, tag_upd_data, tag_wr_data;
    btb_entry_t        btb_pred_data, btb_wr_data;
    logic              bim_wr_en, tag_wr_en, btb_wr_en;

    bpu_decode u_decode (
        .inst_i      (if_inst_i),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .b_imm_o     (b_imm),
        .j_imm_o     (j_imm)
    );

    bpu_lookup #(
        .BIM_ENTRIES (BIM_ENTRIES),
        .TAG_ENTRIES (TAG_ENTRIES),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_lookup (
        .pc_i          (if_pc_i),
        .history_i     (history_o),    // live history, not the execute copy
        .is_branch_i   (is_branch),
        .is_jal_i      (is_jal),
        .is_jalr_i     (is_jalr),
        .b_imm_i       (b_imm),
        .j_imm_i       (j_imm),
        .bim_index_o   (bim_pred_idx),
        .tag_index_o   (tag_pred_idx),
        .btb_index_o   (btb_pred_idx),
        .bim_data_i    (bim_pred_data),
        .tag_data_i    (tag_pred_data),
        .btb_data_i    (btb_pred_data),
        .pred_branch_o (pred_branch_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

    bpu_update #(
        .BIM_ENTRIES (BIM_ENTRIES),
        .TAG_ENTRIES (TAG_ENTRIES),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_update (
        .clk            (clk),
        .rst            (rst),
        .ex_valid_i     (ex_valid_i),
        .ex_taken_i     (ex_taken_i),
        .ex_correct_i   (ex_correct_i),
        .ex_pc_i        (ex_pc_i),
        .ex_history_i   (ex_history_i),
        .ex_target_i    (ex_target_i),
        .history_o      (history_o),
        .bim_index_o    (bim_upd_idx),
        .tag_index_o    (tag_upd_idx),
        .bim_data_i     (bim_upd_data),
        .tag_data_i     (tag_upd_data),
        .bim_wr_en_o    (bim_wr_en),
        .bim_wr_data_o  (bim_wr_data),
        .tag_wr_en_o    (tag_wr_en),
        .tag_wr_data_o  (tag_wr_data),
        .btb_wr_en_o    (btb_wr_en),
        .btb_wr_index_o (btb_wr_idx),
        .btb_wr_data_o  (btb_wr_data)
    );

    // bimodal counters start weak not-taken
    bpu_table #(
        .payload_t   (ctr_t),
        .DEPTH       (BIM_ENTRIES),
        .RESET_VALUE (CTR_WEAK_NT)
    ) bim_table (
        .clk          (clk),
        .rst          (rst),
        .pred_index_i (bim_pred_idx),
        .pred_data_o  (bim_pred_data),
        .upd_index_i  (bim_upd_idx),
        .upd_data_o   (bim_upd_data),
        .wr_en_i      (bim_wr_en),
        .wr_index_i   (bim_upd_idx),   // read-modify-write at the update index
        .wr_data_i    (bim_wr_data)
    );

    bpu_table #(
        .payload_t   (tag_entry_t),
        .DEPTH       (TAG_ENTRIES),
        .RESET_VALUE ('0)
    ) tag_table (
        .clk          (clk),
        .rst          (rst),
        .pred_index_i (tag_pred_idx),
        .pred_data_o  (tag_pred_data),
        .upd_index_i  (tag_upd_idx),
        .upd_data_o   (tag_upd_data),
        .wr_en_i      (tag_wr_en),
        .wr_index_i   (tag_upd_idx),
        .wr_data_i    (tag_wr_data)
    );

    // buffer writes never need the old entry
    bpu_table #(
        .payload_t   (btb_entry_t),
        .DEPTH       (BTB_ENTRIES),
        .RESET_VALUE ('0)
    ) btb_table (
        .clk          (clk),
        .rst          (rst),
        .pred_index_i (btb_pred_idx),
        .pred_data_o  (btb_pred_data),
        .upd_index_i  ('0),
        .upd_data_o   (),
        .wr_en_i      (btb_wr_en),
        .wr_index_i   (btb_wr_idx),
        .wr_data_i    (btb_wr_data)
    );

endmodule

`default_nettype wire

// ==== bpu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

// bound into bpu_top, sees only the top level ports
module bpu_assertions import bpu_pkg::*; (
    input wire   clk,
    input wire   rst,
    input addr_t if_pc_i,
    input wire   pred_branch_o,
    input wire   pred_taken_o,
    input addr_t pred_target_o,
    input hist_t history_o
);

    int fail_count = 0;  // read by the testbench at the end

    a_taken_is_branch: assert property (
        @(posedge clk) disable iff (rst) pred_taken_o |-> pred_branch_o
    ) else begin
        fail_count++;
        $error("taken prediction on a non control transfer");
    end

    // fall through target for everything that is not a transfer
    a_fallthrough: assert property (
        @(posedge clk) disable iff (rst) !pred_branch_o |-> (pred_target_o == if_pc_i + 32'd4)
    ) else begin
        fail_count++;
        $error("non-branch target is not pc+4");
    end

    a_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown({pred_branch_o, pred_taken_o, pred_target_o, history_o})
    ) else begin
        fail_count++;
        $error("unknown value on a prediction output");
    end

endmodule

`default_nettype wire

// ==== tb_bpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bpu import bpu_pkg::*; ();

    localparam int BIM_ENTRIES     = 512;
    localparam int TAG_ENTRIES     = 256;
    localparam int BTB_ENTRIES     = 256;
    localparam int BIM_IW          = $clog2(BIM_ENTRIES);
    localparam int TAG_IW          = $clog2(TAG_ENTRIES);
    localparam int BTB_IW          = $clog2(BTB_ENTRIES);
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 64;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);

    logic  clk;
    logic  rst;
    addr_t if_pc_i;
    inst_t if_inst_i;
    logic  ex_valid_i;
    logic  ex_taken_i;
    logic  ex_correct_i;
    addr_t ex_pc_i;
    hist_t ex_history_i;
    addr_t ex_target_i;
    logic  pred_branch_o;
    logic  pred_taken_o;
    addr_t pred_target_o;
    hist_t history_o;

    // reference model state
    ctr_t       bim_m [BIM_ENTRIES];
    tag_entry_t tag_m [TAG_ENTRIES];
    btb_entry_t btb_m [BTB_ENTRIES];
    hist_t      hist_m;

    logic [31:0] lfsr = 32'hfb00;
    int          test_errs = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;

    bpu_top #(
        .BIM_ENTRIES (BIM_ENTRIES),
        .TAG_ENTRIES (TAG_ENTRIES),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) uut (
        .clk           (clk),
        .rst           (rst),
        .if_pc_i       (if_pc_i),
        .if_inst_i     (if_inst_i),
        .ex_valid_i    (ex_valid_i),
        .ex_taken_i    (ex_taken_i),
        .ex_correct_i  (ex_correct_i),
        .ex_pc_i       (ex_pc_i),
        .ex_history_i  (ex_history_i),
        .ex_target_i   (ex_target_i),
        .pred_branch_o (pred_branch_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .history_o     (history_o)
    );

    bind bpu_top bpu_assertions u_assertions (
        .clk           (clk),
        .rst           (rst),
        .if_pc_i       (if_pc_i),
        .pred_branch_o (pred_branch_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .history_o     (history_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic inst_t enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic ctr_t sat_step(input ctr_t c, input logic up);
        if (up) begin
            return (c == CTR_STRONG_T) ? c : c + 2'd1;
        end
        return (c == CTR_STRONG_NT) ? c : c - 2'd1;
    endfunction

    task automatic model_predict(input addr_t pc, input inst_t inst, output logic br,
                                 output logic tk, output addr_t tgt);
        addr_t             bimm;
        addr_t             jimm;
        logic [TAG_IW-1:0] ti;
        logic              thit;
        logic              bhit;
        logic              dir;
        bimm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        jimm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        ti   = pc[2 +: TAG_IW] ^ hist_m[TAG_IW-1:0];
        thit = tag_m[ti].valid
            && tag_m[ti].tag == (pc[2+TAG_IW +: TAG_WIDTH] ^ hist_m[15 -: TAG_WIDTH]);
        bhit = btb_m[pc[2 +: BTB_IW]].valid && btb_m[pc[2 +: BTB_IW]].tag == pc[31 -: 22];
        dir  = thit ? tag_m[ti].ctr[1] : bim_m[pc[2 +: BIM_IW]][1];
        br   = 1'b1;
        tk   = 1'b0;
        tgt  = pc + 32'd4;
        if (inst[6:0] == OPC_JALR) begin
            tk = bhit;
            if (bhit) tgt = btb_m[pc[2 +: BTB_IW]].target;
        end else if (inst[6:0] == OPC_JAL) begin
            tk  = 1'b1;
            tgt = bhit ? btb_m[pc[2 +: BTB_IW]].target : pc + jimm;
        end else if (inst[6:0] == OPC_BRANCH) begin
            tk = dir;
            if (dir) tgt = bhit ? btb_m[pc[2 +: BTB_IW]].target : pc + bimm;
        end else begin
            br = 1'b0;
        end
    endtask

    // applied at the edge that samples the feedback
    task automatic model_update();
        logic [BIM_IW-1:0]    bi;
        logic [TAG_IW-1:0]    ti;
        logic [TAG_WIDTH-1:0] tg;
        logic                 thit;
        bi   = ex_pc_i[2 +: BIM_IW];
        ti   = ex_pc_i[2 +: TAG_IW] ^ ex_history_i[TAG_IW-1:0];
        tg   = ex_pc_i[2+TAG_IW +: TAG_WIDTH] ^ ex_history_i[15 -: TAG_WIDTH];
        thit = tag_m[ti].valid && tag_m[ti].tag == tg;
        bim_m[bi] = sat_step(bim_m[bi], ex_taken_i);
        if (thit && ex_correct_i) begin
            tag_m[ti].ctr = sat_step(tag_m[ti].ctr, ex_taken_i);
        end else if (thit) begin
            tag_m[ti].ctr = ex_taken_i ? CTR_STRONG_T : CTR_STRONG_NT;
        end else if (!ex_correct_i) begin
            tag_m[ti] = '{valid: 1'b1, tag: tg, ctr: ex_taken_i ? CTR_WEAK_T : CTR_WEAK_NT};
        end
        if (ex_taken_i) begin
            btb_m[ex_pc_i[2 +: BTB_IW]] = '{valid: 1'b1, tag: ex_pc_i[31 -: 22],
                                            target: ex_target_i};
        end
        hist_m = {hist_m[14:0], ex_taken_i};
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_history(input string name, input hist_t exp, input hist_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic fetch(input addr_t pc, input inst_t inst);
        if_pc_i   = pc;
        if_inst_i = inst;
    endtask

    task automatic feedback(input logic tk, input logic ok, input addr_t pc,
                            input hist_t h, input addr_t tgt);
        ex_valid_i   = 1'b1;
        ex_taken_i   = tk;
        ex_correct_i = ok;
        ex_pc_i      = pc;
        ex_history_i = h;
        ex_target_i  = tgt;
    endtask

    task automatic no_feedback();
        ex_valid_i = 1'b0;
    endtask

    // explicit expectation, checked once the combinational outputs settle
    task automatic expect_pred(input logic tk, input addr_t tgt);
        #1;
        check_bit("pred_taken_o", tk, pred_taken_o);
        check_addr("pred_target_o", tgt, pred_target_o);
    endtask

    // compare mid-cycle, then mirror the edge in the model
    task automatic tick();
        logic  br;
        logic  tk;
        addr_t tgt;
        @(negedge clk);
        model_predict(if_pc_i, if_inst_i, br, tk, tgt);
        check_bit("pred_branch_o", br, pred_branch_o);
        check_bit("pred_taken_o", tk, pred_taken_o);
        check_addr("pred_target_o", tgt, pred_target_o);
        check_history("history_o", hist_m, history_o);
        @(posedge clk);
        if (ex_valid_i) model_update();
        #1;
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic random_cycle();
        logic  br;
        logic  tk;
        addr_t tgt;
        addr_t pc;
        inst_t inst;
        logic  outcome;
        logic [2:0] sel;
        pc   = 32'h1000 | (rand_bits(1) != 0 ? 32'h0040_0000 : 32'h0) | (rand_bits(4) << 2);
        sel  = 3'(rand_bits(3));
        inst = rand_bits(32);
        if (sel < 3'd3) inst[6:0] = OPC_BRANCH;        // biased toward transfers
        else if (sel < 3'd5) inst[6:0] = OPC_JAL;
        else if (sel == 3'd5) inst[6:0] = OPC_JALR;
        else inst[6:0] = 7'b0010011;
        fetch(pc, inst);
        model_predict(pc, inst, br, tk, tgt);
        outcome = (rand_bits(1) != 0);
        if (br && rand_bits(2) != 0) begin
            feedback(outcome, outcome == tk, pc, hist_m, pc + (rand_bits(8) << 2));
        end else begin
            no_feedback();
        end
        tick();
    endtask

    initial begin
        for (int i = 0; i < BIM_ENTRIES; i++) bim_m[i] = CTR_WEAK_NT;
        for (int i = 0; i < TAG_ENTRIES; i++) tag_m[i] = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) btb_m[i] = '0;
        hist_m = '0;
        rst = 1'b1;
        if_pc_i = '0;
        if_inst_i = 32'h0000_0013;
        ex_valid_i = 1'b0;
        ex_taken_i = 1'b0;
        ex_correct_i = 1'b0;
        ex_pc_i = '0;
        ex_history_i = '0;
        ex_target_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;

        // after reset
        check_history("history_o", 16'h0000, history_o);
        fetch(32'h100, 32'h0000_0013);
        expect_pred(1'b0, 32'h104);
        tick();
        fetch(32'h200, enc_branch(13'd16));
        expect_pred(1'b0, 32'h204);
        tick();
        fetch(32'h300, enc_jal(21'h40));
        expect_pred(1'b1, 32'h340);
        tick();
        fetch(32'h400, {20'h0, 5'd1, OPC_JALR});
        expect_pred(1'b0, 32'h404);
        tick();
        end_test("reset_state");

        // bimodal training both ways
        fetch(32'h1200, enc_branch(13'h20));
        repeat (2) begin
            feedback(1'b1, 1'b1, 32'h1200, hist_m, 32'h1220);
            tick();
        end
        no_feedback();
        expect_pred(1'b1, 32'h1220);
        tick();
        repeat (2) begin
            feedback(1'b0, 1'b1, 32'h1200, hist_m, 32'h1204);
            tick();
        end
        no_feedback();
        expect_pred(1'b0, 32'h1204);
        tick();
        end_test("bimodal");

        // target buffer, then same index with another tag
        fetch(32'h100, 32'h0000_0013);
        feedback(1'b1, 1'b0, 32'h2000, hist_m, 32'h8000);
        tick();
        no_feedback();
        fetch(32'h2000, {20'h0, 5'd1, OPC_JALR});
        expect_pred(1'b1, 32'h8000);
        tick();
        fetch(32'h2000, enc_jal(21'h100));
        expect_pred(1'b1, 32'h8000);
        tick();
        fetch(32'h2000, enc_branch(13'h40));
        expect_pred(1'b1, 32'h8000);
        tick();
        fetch(32'h2400, {20'h0, 5'd1, OPC_JALR});
        expect_pred(1'b0, 32'h2404);
        tick();
        end_test("target_buffer");

        // bimodal says taken, allocated tagged entry says not taken
        fetch(32'h3000, enc_branch(13'h40));
        repeat (2) begin
            feedback(1'b1, 1'b1, 32'h3000, hist_m, 32'h3040);
            tick();
        end
        feedback(1'b0, 1'b0, 32'h3000, {hist_m[14:0], 1'b0}, 32'h3004);
        tick();
        no_feedback();
        expect_pred(1'b0, 32'h3004);
        check_history("history_o", 16'h00ce, history_o);
        tick();
        end_test("tagged_override");

        repeat (RANDOM_CYCLES) random_cycle();
        no_feedback();
        end_test("random_stream");

        if (uut.u_assertions.fail_count != 0) begin
            $display("%0d assertion failures were seen", uut.u_assertions.fail_count);
            fail_count++;
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bpu.f ====
bpu_pkg.sv
bpu_table.sv
bpu_decode.sv
bpu_lookup.sv
bpu_update.sv
bpu_top.sv
bpu_assertions.sv
tb_bpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= bpu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# status comes from the pass line, not from the exit code
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
